// ==== include/snes_mem_config.svh ====
// ==========================================================
// Memory depth, work-RAM region and cartridge header offsets
// ==========================================================
`ifndef SNES_MEM_CONFIG_SVH
`define SNES_MEM_CONFIG_SVH

// Shared word memory, 2^18 words
`define SNES_MEM_WORD_BITS   18
// Top word-address bit, set for work RAM
`define SNES_WRAM_REGION     1'b1

// Internal header fields, offsets inside the header bank
`define SNES_HDR_MAPPER      15'h7FD4
`define SNES_HDR_TYPE        15'h7FD6
`define SNES_HDR_RAMSIZE     15'h7FD8
`define SNES_HDR_COMPANY     15'h7FDA

`define SNES_LOROM_PREFIX    9'h000
`define SNES_HIROM_PREFIX    9'h001
`define SNES_EXHIROM_PREFIX  9'h081
`define SNES_MIN_ROM_SHIFT   4'd12

`endif

// ==== hw/snes_mem_pkg.sv ====
// ==========================================================
// Vector types and state enums for the cartridge memory
// ==========================================================
`include "snes_mem_config.svh"

package snes_mem_pkg;

	// Memory side
	typedef logic [15:0] mem_word_t;
	typedef logic [`SNES_MEM_WORD_BITS-1:0] mem_addr_t;
	typedef logic [1:0] lane_t;

	// CPU and download side
	typedef logic [23:0] cart_addr_t;
	typedef logic [16:0] wram_addr_t;
	typedef logic [7:0] byte_t;

	// Coprocessor code in [7:4], map in [1:0]
	typedef logic [7:0] rom_type_t;
	typedef logic [23:0] mask_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_RETURN
	} arb_state_e;

endpackage

// ==== hw/cart_loader.sv ====
// ==========================================================
// Cartridge download peer, copier header skip and word writes
// ==========================================================
`include "snes_mem_config.svh"

module cart_loader (
	input  logic                    clk_sys,
	input  logic                    RESET_N,
	input  logic                    ioctl_download,
	input  snes_mem_pkg::byte_t     ioctl_index,
	input  logic                    ioctl_wr,
	input  snes_mem_pkg::cart_addr_t ioctl_addr,
	input  snes_mem_pkg::mem_word_t ioctl_dout,
	input  snes_mem_pkg::cart_addr_t ioctl_filesize,
	input  logic                    loader_ack,
	output logic                    loader_req,
	output snes_mem_pkg::mem_addr_t loader_addr,
	output snes_mem_pkg::mem_word_t loader_din,
	output logic                    ioctl_wait,
	output logic                    cart_download,
	output snes_mem_pkg::cart_addr_t cart_addr_adj
);

	// Indices 0 and 1 are cartridge images
	assign cart_download = ioctl_download && (ioctl_index[5:1] == 5'd0);

	// Low ten bits of the size are the 512-byte copier header, if any
	assign cart_addr_adj = ioctl_addr - {14'd0, ioctl_filesize[9:0]};

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			loader_req <= 1'b0;
			ioctl_wait <= 1'b0;
		end else if (cart_download && ioctl_wr) begin
			loader_req <= ~loader_req;
			ioctl_wait <= 1'b1;
		end else if (loader_ack) begin
			ioctl_wait <= 1'b0;
		end
	end

	// Word address lands in the ROM half of the memory
	always_ff @(posedge clk_sys) begin
		if (cart_download && ioctl_wr) begin
			loader_addr <= {~`SNES_WRAM_REGION, cart_addr_adj[`SNES_MEM_WORD_BITS-1:1]};
			loader_din <= ioctl_dout;
		end
	end

	// Source holds off the next word until the previous one is stored
	assert property (@(posedge clk_sys) disable iff (!RESET_N) ioctl_wait |-> !ioctl_wr)
		else $error("ioctl_wr while ioctl_wait is high");

endmodule

// ==== hw/rom_header_detect.sv ====
// ==========================================================
// Cartridge header capture, ROM type decode, ROM and RAM masks
// ==========================================================
`include "snes_mem_config.svh"

module rom_header_detect (
	input  logic                     clk_sys,
	input  logic                     RESET_N,
	input  logic                     cart_download,
	input  logic                     ioctl_wr,
	input  snes_mem_pkg::cart_addr_t ioctl_addr,
	input  snes_mem_pkg::cart_addr_t cart_addr_adj,
	input  snes_mem_pkg::mem_word_t  ioctl_dout,
	input  snes_mem_pkg::byte_t      ioctl_index,
	input  logic [1:0]               rom_map,
	output snes_mem_pkg::rom_type_t  rom_type,
	output snes_mem_pkg::mask_t      rom_mask,
	output snes_mem_pkg::mask_t      ram_mask
);
	import snes_mem_pkg::*;

	byte_t mapper_hdr;
	byte_t type_hdr;
	byte_t company_hdr;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic [3:0] rom_shift;
	logic [1:0] map_sel;
	logic [8:0] hdr_prefix;

	// Map from the menu, or from the download index when set to auto
	assign map_sel = (rom_map == 2'd0) ? ioctl_index[7:6] : rom_map - 2'd1;
	assign hdr_prefix = (map_sel == 2'd2) ? `SNES_EXHIROM_PREFIX :
	                    (map_sel == 2'd1) ? `SNES_HIROM_PREFIX : `SNES_LOROM_PREFIX;
	assign rom_shift = (rom_size < 4'd7) ? `SNES_MIN_ROM_SHIFT : rom_size;

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			rom_type <= '0;
			rom_mask <= '0;
			ram_mask <= '0;
			mapper_hdr <= '0;
			type_hdr <= '0;
			company_hdr <= '0;
			rom_size <= '0;
			ram_size <= '0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				if (ioctl_addr == 24'd0) begin
					ram_size <= 4'h0;
					rom_type <= {6'd0, map_sel};
				end
				if (cart_addr_adj == {hdr_prefix, `SNES_HDR_MAPPER})
					mapper_hdr <= ioctl_dout[15:8];
				if (cart_addr_adj == {hdr_prefix, `SNES_HDR_TYPE})
					{rom_size, type_hdr} <= ioctl_dout[11:0];
				if (cart_addr_adj == {hdr_prefix, `SNES_HDR_RAMSIZE})
					ram_size <= ioctl_dout[3:0];
				if (cart_addr_adj == {hdr_prefix, `SNES_HDR_COMPANY})
					company_hdr <= ioctl_dout[7:0];

				rom_mask <= (24'd1024 << rom_shift) - 24'd1;
				ram_mask <= (ram_size != 4'd0) ? (24'd1024 << ram_size) - 24'd1 : 24'd0;
			end
		end else begin
			// ======================================================
			// Coprocessor decode, first match wins
			// ======================================================
			if (mapper_hdr == 8'h30 && type_hdr == 8'h05 && company_hdr == 8'hB2) begin
				rom_type[7:4] <= 4'hA;
			end else if (((mapper_hdr == 8'h20 || mapper_hdr == 8'h21) && type_hdr == 8'h03) ||
			             (mapper_hdr == 8'h30 && type_hdr == 8'h05) ||
			             (mapper_hdr == 8'h31 && (type_hdr == 8'h03 || type_hdr == 8'h05))) begin
				// DSP1 keeps the lower nibble of the code
				rom_type[7] <= 1'b1;
			end else if (mapper_hdr == 8'h20 && type_hdr == 8'h05) begin
				rom_type[7:4] <= 4'h9;
			end else if (mapper_hdr == 8'h30 && type_hdr == 8'h03) begin
				rom_type[7:4] <= 4'hB;
			end else if (mapper_hdr == 8'h30 && type_hdr == 8'h25) begin
				rom_type[7:4] <= 4'hC;
			end else if (mapper_hdr == 8'h32 && (type_hdr == 8'h43 || type_hdr == 8'h45)) begin
				rom_type[7:4] <= 4'h5;
			end else if (mapper_hdr == 8'h30 && type_hdr == 8'hF6) begin
				rom_type[7:3] <= {4'h8, 1'b1};
				// Small ST0xx carts need the extra variant bit
				if (rom_size < 4'd10)
					rom_type[5] <= 1'b1;
			end else if (mapper_hdr == 8'h20 && (type_hdr == 8'h13 || type_hdr == 8'h14 ||
			                                     type_hdr == 8'h15 || type_hdr == 8'h1A)) begin
				// GSU always gets 64K of save RAM
				rom_type[7:4] <= 4'h7;
				ram_mask <= (24'd1024 << 6) - 24'd1;
			end else if (mapper_hdr == 8'h23 && (type_hdr == 8'h32 || type_hdr == 8'h34 ||
			                                     type_hdr == 8'h35)) begin
				rom_type[7:4] <= 4'h6;
			end else if (mapper_hdr == 8'h3A && (type_hdr == 8'hF5 || type_hdr == 8'hF9)) begin
				rom_type[7:4] <= 4'hD;
				rom_type[3] <= type_hdr[3];    // RTC variant
			end else if (mapper_hdr == 8'h20 && type_hdr == 8'hF3) begin
				rom_type[7:4] <= 4'h4;
			end
		end
	end

endmodule

// ==== hw/rom_port.sv ====
// ==========================================================
// CPU ROM read peer with one-word cache and odd-byte swap
// ==========================================================
`include "snes_mem_config.svh"

module rom_port (
	input  logic                     clk_sys,
	input  logic                     RESET_N,
	input  snes_mem_pkg::cart_addr_t rom_addr,
	input  logic                     rom_ce_n,
	input  logic                     rom_word,
	input  logic                     rom_ack,
	input  snes_mem_pkg::mem_word_t  mem_q,
	output logic                     rom_req,
	output snes_mem_pkg::mem_addr_t  rom_word_addr,
	output snes_mem_pkg::mem_word_t  rom_q,
	output logic                     rom_busy
);
	import snes_mem_pkg::*;

	mem_word_t fetched;
	mem_addr_t want_addr;
	logic cache_valid;
	logic miss;

	assign want_addr = {~`SNES_WRAM_REGION, rom_addr[`SNES_MEM_WORD_BITS-1:1]};
	assign miss = !rom_ce_n && !rom_busy && (!cache_valid || want_addr != rom_word_addr);

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			rom_req <= 1'b0;
			rom_busy <= 1'b0;
			cache_valid <= 1'b0;
		end else begin
			if (miss) begin
				rom_req <= ~rom_req;
				rom_busy <= 1'b1;
				cache_valid <= 1'b1;
			end else if (rom_ack) begin
				rom_busy <= 1'b0;
			end
			// Cache only lives while the chip stays selected
			if (rom_ce_n)
				cache_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (miss)
			rom_word_addr <= want_addr;
		if (rom_ack)
			fetched <= mem_q;
	end

	// Odd byte reads see the high byte in the low lane
	assign rom_q = (rom_word || !rom_addr[0]) ? fetched : {fetched[7:0], fetched[15:8]};

endmodule

// ==== hw/wram_port.sv ====
// ==========================================================
// CPU work-RAM peer, strobe edges and byte-lane selection
// ==========================================================
`include "snes_mem_config.svh"

module wram_port (
	input  logic                     clk_sys,
	input  logic                     RESET_N,
	input  snes_mem_pkg::wram_addr_t wram_addr,
	input  snes_mem_pkg::byte_t      wram_d,
	input  logic                     wram_ce_n,
	input  logic                     wram_rd_n,
	input  logic                     wram_we_n,
	input  logic                     wram_ack,
	input  snes_mem_pkg::mem_word_t  mem_q,
	output logic                     wram_req,
	output snes_mem_pkg::mem_addr_t  wram_word_addr,
	output snes_mem_pkg::mem_word_t  wram_din,
	output logic                     wram_we,
	output snes_mem_pkg::lane_t      wram_lanes,
	output snes_mem_pkg::byte_t      wram_q,
	output logic                     wram_busy
);
	import snes_mem_pkg::*;

	mem_word_t fetched;
	logic rd, wr, rd_d, wr_d;
	logic start;

	assign rd = !wram_ce_n && !wram_rd_n;
	assign wr = !wram_ce_n && !wram_we_n;

	// New strobe, or a held read that moved to another word
	assign start = !wram_busy && ((rd && !rd_d) || (wr && !wr_d) ||
	                              (rd && wram_word_addr[15:0] != wram_addr[16:1]));

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			wram_req <= 1'b0;
			wram_busy <= 1'b0;
			rd_d <= 1'b0;
			wr_d <= 1'b0;
		end else begin
			rd_d <= rd;
			wr_d <= wr;
			if (start) begin
				wram_req <= ~wram_req;
				wram_busy <= 1'b1;
			end else if (wram_ack) begin
				wram_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start) begin
			wram_word_addr <= {`SNES_WRAM_REGION, 1'b0, wram_addr[16:1]};
			wram_din <= {wram_d, wram_d};
			wram_we <= wr;
			wram_lanes <= {wram_addr[0], ~wram_addr[0]};
		end
		if (wram_ack && !wram_we)
			fetched <= mem_q;
	end

	assign wram_q = wram_addr[0] ? fetched[15:8] : fetched[7:0];

endmodule

// ==== hw/mem_arbiter.sv ====
// ==========================================================
// Fixed-priority arbiter and the shared word memory
// ==========================================================
`include "snes_mem_config.svh"

module mem_arbiter (
	input  logic                    clk_sys,
	input  logic                    RESET_N,
	input  logic                    loader_req,
	input  snes_mem_pkg::mem_addr_t loader_addr,
	input  snes_mem_pkg::mem_word_t loader_din,
	input  logic                    rom_req,
	input  snes_mem_pkg::mem_addr_t rom_word_addr,
	input  logic                    wram_req,
	input  snes_mem_pkg::mem_addr_t wram_word_addr,
	input  snes_mem_pkg::mem_word_t wram_din,
	input  logic                    wram_we,
	input  snes_mem_pkg::lane_t     wram_lanes,
	output logic                    loader_ack,
	output logic                    rom_ack,
	output logic                    wram_ack,
	output snes_mem_pkg::mem_word_t mem_q
);
	import snes_mem_pkg::*;

	mem_word_t mem [0:(1 << `SNES_MEM_WORD_BITS)-1];
	arb_state_e state;
	logic loader_seen, rom_seen, wram_seen;
	logic take_loader, take_rom, take_wram;
	logic [2:0] grant;    // wram, rom, loader
	mem_addr_t rd_addr;

	// ======================================================
	// Grant selection, loader first
	// ======================================================
	assign take_loader = (state == ARB_IDLE) && (loader_req != loader_seen);
	assign take_rom = (state == ARB_IDLE) && !take_loader && (rom_req != rom_seen);
	assign take_wram = (state == ARB_IDLE) && !take_loader && !take_rom &&
	                   (wram_req != wram_seen);
	assign rd_addr = take_rom ? rom_word_addr : wram_word_addr;

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			state <= ARB_IDLE;
			grant <= 3'b000;
			loader_seen <= 1'b0;
			rom_seen <= 1'b0;
			wram_seen <= 1'b0;
		end else if (state == ARB_IDLE) begin
			if (take_loader || take_rom || take_wram)
				state <= ARB_RETURN;
			grant <= {take_wram, take_rom, take_loader};
			if (take_loader)
				loader_seen <= loader_req;
			if (take_rom)
				rom_seen <= rom_req;
			if (take_wram)
				wram_seen <= wram_req;
		end else begin
			state <= ARB_IDLE;
		end
	end

	// Memory array
	always_ff @(posedge clk_sys) begin
		if (take_loader)
			mem[loader_addr] <= loader_din;
		if (take_wram && wram_we && wram_lanes[1])
			mem[wram_word_addr][15:8] <= wram_din[15:8];
		if (take_wram && wram_we && wram_lanes[0])
			mem[wram_word_addr][7:0] <= wram_din[7:0];
		if (take_rom || take_wram)
			mem_q <= mem[rd_addr];
	end

	assign loader_ack = (state == ARB_RETURN) && grant[0];
	assign rom_ack = (state == ARB_RETURN) && grant[1];
	assign wram_ack = (state == ARB_RETURN) && grant[2];

	// A peer toggles again only after its acknowledge
	assert property (@(posedge clk_sys) disable iff (!RESET_N)
		(!loader_ack || loader_req == loader_seen) &&
		(!rom_ack || rom_req == rom_seen) &&
		(!wram_ack || wram_req == wram_seen))
		else $error("request toggled again before its acknowledge");

endmodule

// ==== hw/snes_mem_top.sv ====
// ==========================================================
// Cartridge memory top, download, CPU ports and arbiter
// ==========================================================
module snes_mem_top (
	input  logic                     clk_sys,
	input  logic                     RESET_N,
	input  logic                     ioctl_download,
	input  snes_mem_pkg::byte_t      ioctl_index,
	input  logic                     ioctl_wr,
	input  snes_mem_pkg::cart_addr_t ioctl_addr,
	input  snes_mem_pkg::mem_word_t  ioctl_dout,
	input  snes_mem_pkg::cart_addr_t ioctl_filesize,
	input  logic [1:0]               rom_map,
	output logic                     ioctl_wait,
	input  snes_mem_pkg::cart_addr_t rom_addr,
	input  logic                     rom_ce_n,
	input  logic                     rom_word,
	output snes_mem_pkg::mem_word_t  rom_q,
	output logic                     rom_busy,
	input  snes_mem_pkg::wram_addr_t wram_addr,
	input  snes_mem_pkg::byte_t      wram_d,
	input  logic                     wram_ce_n,
	input  logic                     wram_rd_n,
	input  logic                     wram_we_n,
	output snes_mem_pkg::byte_t      wram_q,
	output logic                     wram_busy,
	output snes_mem_pkg::rom_type_t  rom_type,
	output snes_mem_pkg::mask_t      rom_mask,
	output snes_mem_pkg::mask_t      ram_mask
);
	import snes_mem_pkg::*;

	logic loader_req, loader_ack, rom_req, rom_ack, wram_req, wram_ack;
	logic wram_we, cart_download;
	mem_addr_t loader_addr, rom_word_addr, wram_word_addr;
	mem_word_t loader_din, wram_din, mem_q;
	lane_t wram_lanes;
	cart_addr_t cart_addr_adj;

	cart_loader u_loader (
		.clk_sys(clk_sys), .RESET_N(RESET_N),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_filesize(ioctl_filesize), .loader_ack(loader_ack),
		.loader_req(loader_req), .loader_addr(loader_addr), .loader_din(loader_din),
		.ioctl_wait(ioctl_wait), .cart_download(cart_download),
		.cart_addr_adj(cart_addr_adj)
	);

	rom_header_detect u_detect (
		.clk_sys(clk_sys), .RESET_N(RESET_N), .cart_download(cart_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .cart_addr_adj(cart_addr_adj),
		.ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index), .rom_map(rom_map),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask)
	);

	rom_port u_rom (
		.clk_sys(clk_sys), .RESET_N(RESET_N), .rom_addr(rom_addr),
		.rom_ce_n(rom_ce_n), .rom_word(rom_word), .rom_ack(rom_ack), .mem_q(mem_q),
		.rom_req(rom_req), .rom_word_addr(rom_word_addr), .rom_q(rom_q),
		.rom_busy(rom_busy)
	);

	wram_port u_wram (
		.clk_sys(clk_sys), .RESET_N(RESET_N), .wram_addr(wram_addr), .wram_d(wram_d),
		.wram_ce_n(wram_ce_n), .wram_rd_n(wram_rd_n), .wram_we_n(wram_we_n),
		.wram_ack(wram_ack), .mem_q(mem_q), .wram_req(wram_req),
		.wram_word_addr(wram_word_addr), .wram_din(wram_din), .wram_we(wram_we),
		.wram_lanes(wram_lanes), .wram_q(wram_q), .wram_busy(wram_busy)
	);

	mem_arbiter u_arb (
		.clk_sys(clk_sys), .RESET_N(RESET_N),
		.loader_req(loader_req), .loader_addr(loader_addr), .loader_din(loader_din),
		.rom_req(rom_req), .rom_word_addr(rom_word_addr),
		.wram_req(wram_req), .wram_word_addr(wram_word_addr), .wram_din(wram_din),
		.wram_we(wram_we), .wram_lanes(wram_lanes),
		.loader_ack(loader_ack), .rom_ack(rom_ack), .wram_ack(wram_ack), .mem_q(mem_q)
	);

endmodule

// ==== verification/tb_clock.sv ====
// ==========================================================
// Testbench clock at 20 ns and a ten-cycle reset
// ==========================================================
module tb_clock (
	output logic clk_sys,
	output logic RESET_N
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		RESET_N = 1'b0;
		repeat (10) @(posedge clk_sys);
		RESET_N <= 1'b1;
	end

endmodule

// ==== verification/tb_checker.sv ====
// ==========================================================
// Shadow memory, read compares and error counts
// ==========================================================
module tb_checker (
	input logic        clk_sys,
	input logic        RESET_N,
	input logic        ioctl_download,
	input logic [7:0]  ioctl_index,
	input logic        ioctl_wr,
	input logic [23:0] ioctl_addr,
	input logic [15:0] ioctl_dout,
	input logic [23:0] ioctl_filesize,
	input logic        ioctl_wait,
	input logic [23:0] rom_addr,
	input logic        rom_ce_n,
	input logic        rom_word,
	input logic [15:0] rom_q,
	input logic        rom_busy,
	input logic [16:0] wram_addr,
	input logic [7:0]  wram_d,
	input logic        wram_ce_n,
	input logic        wram_rd_n,
	input logic        wram_we_n,
	input logic [7:0]  wram_q,
	input logic        wram_busy,
	input logic [7:0]  rom_type,
	input logic [23:0] rom_mask,
	input logic [23:0] ram_mask
);
	timeunit 1ns;
	timeprecision 1ps;

	int errors = 0;
	int timeouts = 0;
	logic [15:0] shadow [int];
	logic rom_busy_d = 1'b0;
	logic wram_busy_d = 1'b0;
	logic wr_d = 1'b0;
	logic load_d = 1'b0;

	task automatic compare(input string name, input logic [23:0] expected,
		input logic [23:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %0d ns %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout at %0d ns while waiting for %s", $time, what);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error at %0d ns: %s", $time, what);
	endtask

	task automatic check_header(input logic [7:0] exp_type, input logic [23:0] exp_rom,
		input logic [23:0] exp_ram);
		compare("rom_type", {16'd0, exp_type}, {16'd0, rom_type});
		compare("rom_mask", exp_rom, rom_mask);
		compare("ram_mask", exp_ram, ram_mask);
	endtask

	task automatic check_idle();
		compare("ioctl_wait", 24'd0, {23'd0, ioctl_wait});
		compare("rom_busy", 24'd0, {23'd0, rom_busy});
		compare("wram_busy", 24'd0, {23'd0, wram_busy});
		check_header(8'h00, 24'd0, 24'd0);
	endtask

	task automatic print_counts();
		$display("Error counts: %0d check errors, %0d timeouts", errors, timeouts);
	endtask

	always @(posedge clk_sys) begin : watch
		int key;
		logic [15:0] w;
		logic [23:0] adj;
		if (RESET_N) begin
			// Wait must be high on the edge after the strobe was sampled
			if (load_d)
				compare("ioctl_wait", 24'd1, {23'd0, ioctl_wait});
			load_d <= ioctl_download && ioctl_index[5:1] == 5'd0 && ioctl_wr;
			if (ioctl_download && ioctl_index[5:1] == 5'd0 && ioctl_wr) begin
				adj = ioctl_addr - {14'd0, ioctl_filesize[9:0]};
				shadow[int'(adj[17:1])] = ioctl_dout;
			end

			// Work-RAM byte writes start on the strobe edge
			if (!wram_ce_n && !wram_we_n && !wr_d && !wram_busy) begin
				key = 32'h20000 | int'(wram_addr[16:1]);
				w = shadow.exists(key) ? shadow[key] : 16'h0000;
				if (wram_addr[0])
					w[15:8] = wram_d;
				else
					w[7:0] = wram_d;
				shadow[key] = w;
			end
			wr_d <= !wram_ce_n && !wram_we_n;

			if (rom_busy_d && !rom_busy && !rom_ce_n) begin
				key = int'(rom_addr[17:1]);
				if (!shadow.exists(key)) begin
					errors++;
					$display("ROM read at %h returned a word that was never written", rom_addr);
				end else begin
					w = shadow[key];
					if (!rom_word && rom_addr[0])
						w = {w[7:0], w[15:8]};
					compare("rom_q", {8'd0, w}, {8'd0, rom_q});
				end
			end

			if (wram_busy_d && !wram_busy && !wram_ce_n && !wram_rd_n) begin
				key = 32'h20000 | int'(wram_addr[16:1]);
				w = shadow.exists(key) ? shadow[key] : 16'h0000;
				compare("wram_q", {16'd0, wram_addr[0] ? w[15:8] : w[7:0]}, {16'd0, wram_q});
			end
			rom_busy_d <= rom_busy;
			wram_busy_d <= wram_busy;
		end
	end

endmodule

// ==== verification/tb_top.sv ====
// ==========================================================
// Testbench top, pattern reader and DUT stimulus
// ==========================================================
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 40;
	localparam logic [23:0] FILE_SIZE = 24'h080200;

	logic clk_sys, RESET_N;
	logic ioctl_download, ioctl_wr, ioctl_wait;
	logic [7:0] ioctl_index;
	logic [23:0] ioctl_addr, ioctl_filesize;
	logic [15:0] ioctl_dout;
	logic [1:0] rom_map;
	logic [23:0] rom_addr;
	logic rom_ce_n, rom_word, rom_busy;
	logic [15:0] rom_q;
	logic [16:0] wram_addr;
	logic [7:0] wram_d, wram_q;
	logic wram_ce_n, wram_rd_n, wram_we_n, wram_busy;
	logic [7:0] rom_type;
	logic [23:0] rom_mask, ram_mask;
	logic [31:0] rng = 32'h5fd07d7d;
	logic timed_out = 1'b0;

	tb_clock clock_gen (.clk_sys(clk_sys), .RESET_N(RESET_N));
	snes_mem_top UUT (.*);
	tb_checker chk (.*);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] next_word();
		rng = xorshift32(rng);
		return rng[15:0];
	endfunction

	function automatic logic pick(input int which);
		return (which == 0) ? ioctl_wait : (which == 1) ? rom_busy : wram_busy;
	endfunction

	// Polls one handshake line at each rising edge
	task automatic wait_level(input int which, input logic level, input string what);
		int n;
		n = 1;
		@(posedge clk_sys);
		while (pick(which) !== level && n < WAIT_LIMIT) begin
			@(posedge clk_sys);
			n++;
		end
		if (pick(which) !== level) begin
			chk.report_timeout(what);
			timed_out = 1'b1;
		end
	endtask

	task automatic write_word(input logic [23:0] addr, input logic [15:0] data);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		wait_level(0, 1'b0, "ioctl_wait to fall");
	endtask

	task automatic download(input logic [1:0] map, input logic [7:0] index,
		input logic [7:0] mapper, input logic [7:0] htype, input logic [3:0] rom_sz,
		input logic [3:0] ram_sz, input logic [7:0] exp_type, input logic [23:0] exp_rom,
		input logic [23:0] exp_ram);
		logic [1:0] eff;
		logic [23:0] hdr;
		int i;
		eff = (map == 2'd0) ? index[7:6] : map - 2'd1;
		hdr = (eff == 2'd2) ? 24'h408000 : (eff == 2'd1) ? 24'h008000 : 24'h000000;
		hdr = hdr + FILE_SIZE[9:0];
		ioctl_download <= 1'b1;
		ioctl_index <= index;
		rom_map <= map;
		write_word(24'h000000, next_word());
		for (i = 0; i < 6; i++)
			write_word(24'h000300 + 24'(2 * i), next_word());
		write_word(hdr + 24'h7FD4, {mapper, 8'h00});
		write_word(hdr + 24'h7FD6, {4'h0, rom_sz, htype});
		write_word(hdr + 24'h7FD8, {12'h000, ram_sz});
		write_word(hdr + 24'h7FDA, 16'h3301);
		write_word(24'h000400, next_word());
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		chk.check_header(exp_type, exp_rom, exp_ram);
	endtask

	task automatic rom_read(input logic [23:0] addr, input logic word);
		rom_addr <= addr;
		rom_word <= word;
		rom_ce_n <= 1'b0;
		wait_level(1, 1'b1, "rom_busy to rise");
		wait_level(1, 1'b0, "rom_busy to fall");
		rom_ce_n <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic wram_access(input logic [16:0] addr, input logic [7:0] data,
		input logic write);
		wram_addr <= addr;
		wram_d <= data;
		wram_ce_n <= 1'b0;
		wram_we_n <= !write;
		wram_rd_n <= write;
		wait_level(2, 1'b1, "wram_busy to rise");
		wait_level(2, 1'b0, "wram_busy to fall");
		wram_ce_n <= 1'b1;
		wram_we_n <= 1'b1;
		wram_rd_n <= 1'b1;
		@(posedge clk_sys);
	endtask

	// ROM and work-RAM reads start on the same edge
	task automatic contend(input logic [23:0] raddr, input logic [16:0] waddr);
		rom_addr <= raddr;
		rom_word <= 1'b1;
		rom_ce_n <= 1'b0;
		wram_addr <= waddr;
		wram_ce_n <= 1'b0;
		wram_rd_n <= 1'b0;
		wait_level(1, 1'b1, "rom_busy to rise");
		wait_level(2, 1'b1, "wram_busy to rise");
		wait_level(1, 1'b0, "rom_busy to fall");
		wait_level(2, 1'b0, "wram_busy to fall");
		rom_ce_n <= 1'b1;
		wram_ce_n <= 1'b1;
		wram_rd_n <= 1'b1;
		@(posedge clk_sys);
	endtask

	initial begin
		int fd;
		int n;
		string line;
		string op;
		logic [31:0] f [0:8];
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = 24'd0;
		ioctl_dout = 16'd0;
		ioctl_filesize = FILE_SIZE;
		rom_map = 2'd0;
		rom_addr = 24'd0;
		rom_ce_n = 1'b1;
		rom_word = 1'b0;
		wram_addr = 17'd0;
		wram_d = 8'd0;
		wram_ce_n = 1'b1;
		wram_rd_n = 1'b1;
		wram_we_n = 1'b1;

		n = 0;
		while (RESET_N !== 1'b1 && n < 100) begin
			@(posedge clk_sys);
			n++;
		end
		if (RESET_N !== 1'b1) begin
			chk.report_timeout("RESET_N to rise");
			timed_out = 1'b1;
		end
		@(posedge clk_sys);
		@(posedge clk_sys);
		chk.check_idle();

		fd = $fopen("verification/mem_patterns.txt", "r");
		if (fd == 0)
			chk.report_error("the patterns file could not be opened");
		while (fd != 0 && !timed_out && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", op,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
				case (op)
					"D": download(f[0][1:0], f[1][7:0], f[2][7:0], f[3][7:0], f[4][3:0],
						f[5][3:0], f[6][7:0], f[7][23:0], f[8][23:0]);
					"W": wram_access(f[0][16:0], f[1][7:0], 1'b1);
					"V": wram_access(f[0][16:0], 8'h00, 1'b0);
					"R": rom_read(f[0][23:0], f[1][0]);
					"C": contend(f[0][23:0], f[1][16:0]);
					default: chk.report_error({"unknown opcode in patterns file: ", op});
				endcase
			end
		end
		if (fd != 0)
			$fclose(fd);

		chk.print_counts();
		if (chk.errors == 0 && chk.timeouts == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== verification/mem_patterns.txt ====
# D map index mapper type romsize ramsize exp_type exp_rom_mask exp_ram_mask
# W wram_addr data, V wram_addr, R rom_addr word, C rom_addr wram_addr (all hex)
D 1 00 20 00 8 3 00 03FFFF 001FFF
R 000100 1
R 000103 0
D 0 40 21 03 9 1 81 07FFFF 0007FF
D 1 00 20 15 5 5 70 3FFFFF 00FFFF
D 2 00 23 35 A 0 61 0FFFFF 000000
D 1 00 20 F3 7 0 40 01FFFF 000000
R 000102 1
R 000105 0
R 007FD6 1
W 00010 A5
W 00011 3C
W 00011 5A
V 00010
V 00011
C 000108 00011
R 00010A 0

// ==== all.f ====
+incdir+include
hw/snes_mem_pkg.sv
hw/cart_loader.sv
hw/rom_header_detect.sv
hw/rom_port.sv
hw/wram_port.sv
hw/mem_arbiter.sv
hw/snes_mem_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
	exit 0
fi
exit 1
